// ==== bench/cart_sub_assert.sv ====
// handshake and reset properties, bound into cart_sub
// req and ack are taken from the arbiter to store link
module cart_sub_assert (
   input logic clk4,
   input logic reset,
   input logic dl_wr,
   input logic cart_rd,
   input logic cart_wr,
   input logic busy,
   input logic done,
   input logic req,
   input logic ack
);

   int fail_count = 0;

   // --------------------
   // four-phase rules
   ack_after_req: assert property (@(posedge clk4) disable iff (reset) $rose(ack) |-> req)
      else begin
         $error("ack rose while req was low");
         fail_count++;
      end

   req_until_ack: assert property (@(posedge clk4) disable iff (reset) req && !ack |=> req)
      else begin
         $error("req dropped before ack");
         fail_count++;
      end

   // --------------------
   // caller side
   strobe_idle: assert property (@(posedge clk4) disable iff (reset)
                                 (dl_wr || cart_rd || cart_wr) |-> !busy)
      else begin
         $error("strobe while busy, access dropped");
         fail_count++;
      end

   reset_quiet: assert property (@(posedge clk4) reset |=> !busy && !done)
      else begin
         $error("busy or done high after reset");
         fail_count++;
      end

endmodule

// ==== bench/cart_sub_check.sv ====
// reference model of the MBC1 mapping and the download pattern
// watches the DUT ports on the falling edge and compares every completed read
`include "cart_defines.svh"

module cart_sub_check import cart_pkg::*; (
   input  logic       clk4,
   input  logic       reset,
   input  logic       dl_active,
   input  logic       dl_wr,
   input  waddr_t     dl_addr,
   input  word_t      dl_data,
   input  cart_addr_t cart_addr,
   input  logic       cart_rd,
   input  logic       cart_wr,
   input  cart_byte_t cart_di,
   input  cart_byte_t cart_do,
   input  logic       done,
   input  bank_t      exp_bank,    // bank from the stimulus table
   input  int         test_num,
   input  logic       test_end,
   output int         checks,
   output int         errors
);

   logic [4:0] rom_reg;                 // model of the control registers
   ram_bank_t  ram_reg;
   logic       mode;
   logic       ram_en;
   cart_byte_t type_code;
   cart_byte_t rom_code;
   cart_byte_t ram_code;
   word_t      img [waddr_t];           // words that differ from the pattern
   word_t      rd_word;                 // model word behind the current read
   cart_byte_t exp_byte;
   cart_addr_t rd_addr;
   logic       pend;                    // read in flight
   int         test_reads;
   int         test_errs;

   function automatic word_t pattern(waddr_t w);
      return word_t'(32'(w) * 32'h9E37 + 32'(w));
   endfunction

   // --------------------
   // mapping rules
   function automatic bank_t model_bank(cart_addr_t a);
      rom_bank_t rmask;
      ram_bank_t amask;
      rom_bank_t rsel;
      int        i;
      rmask = '0;
      for (i = 0; i < 7; i++)
         rmask[i] = (i <= int'(rom_code));   // n+1 ones, 7 at most
      amask = (ram_code == 8'd1 || ram_code == 8'd2) ? 2'b00 : 2'b11;
      if (type_code < 8'd1 || type_code > 8'd3)
         return bank_t'(a[14:13]);           // plain 32k image
      if (a[15:14] == 2'b00)
         return bank_t'(a[13]);
      if (a[15:14] == 2'b01) begin
         rsel = mode ? {2'b00, rom_reg} : {ram_reg, rom_reg};
         return {1'b0, rsel & rmask, a[13]};
      end
      if (a[15:13] == 3'b101)
         return {1'b1, 6'd0, (mode ? ram_reg : 2'b00) & amask};
      return '0;
   endfunction

   function automatic word_t model_word(waddr_t w);
      return img.exists(w) ? img[w] : pattern(w);
   endfunction

   task automatic ram_write(input cart_addr_t a, input cart_byte_t d);
      waddr_t w;
      word_t  v;
      w = {model_bank(a), a[12:1]};
      v = model_word(w);
      if (a[0])
         v[7:0] = d;                          // odd byte is the low half
      else
         v[15:8] = d;
      img[w] = v;
   endtask

   always @(negedge clk4) begin
      if (reset) begin
         rom_reg = 5'd1;
         ram_reg = '0;
         mode = 1'b0;
         ram_en = 1'b0;
         type_code = '0;
         rom_code = '0;
         ram_code = '0;
         pend = 1'b0;
         checks = 0;
         errors = 0;
         test_reads = 0;
         test_errs = 0;
      end else begin
         if (done && pend) begin
            checks++;
            test_reads++;
            if (cart_do !== exp_byte) begin
               $display("mismatch at %0t: read %h expected %h got %h",
                        $time, rd_addr, exp_byte, cart_do);
               errors++;
               test_errs++;
            end
            pend = 1'b0;
         end
         // --------------------
         // download snooping
         if (dl_active && dl_wr) begin
            if (dl_addr == `HDR_TYPE_WADDR)
               type_code = dl_data[7:0];
            if (dl_addr == `HDR_SIZE_WADDR)
               {rom_code, ram_code} = dl_data;
            if (dl_data == pattern(dl_addr))
               img.delete(dl_addr);
            else
               img[dl_addr] = dl_data;            // header words
         end
         if (!dl_active && cart_rd) begin
            if (model_bank(cart_addr) !== exp_bank) begin
               $display("mismatch at %0t: read %h table bank %h model bank %h",
                        $time, cart_addr, exp_bank, model_bank(cart_addr));
               errors++;
               test_errs++;
            end
            rd_addr = cart_addr;
            rd_word = model_word({model_bank(cart_addr), cart_addr[12:1]});
            exp_byte = cart_addr[0] ? rd_word[7:0] : rd_word[15:8];
            pend = 1'b1;
         end
         // --------------------
         // cart writes to the ram window or the control registers
         if (!dl_active && cart_wr && !cart_rd && ram_en && cart_addr[15:13] == 3'b101)
            ram_write(cart_addr, cart_di);
         if (cart_wr && !cart_addr[15]) begin
            case (cart_addr[14:13])
               2'd0: ram_en = (cart_di[3:0] == 4'hA);
               2'd1: rom_reg = (cart_di[4:0] == 5'd0) ? 5'd1 : cart_di[4:0];
               2'd2: ram_reg = cart_di[1:0];
               default: mode = cart_di[0];
            endcase
         end
         if (test_end) begin
            $display("test %0d finished: %0d reads, %0d errors", test_num, test_reads, test_errs);
            test_reads = 0;
            test_errs = 0;
         end
      end
   end

endmodule

// ==== bench/cart_sub_tb.sv ====
// testbench for the cartridge subsystem with one access in flight at a time
// each row downloads words 0..7 of every 8k bank and reads stay inside them
`include "cart_defines.svh"

module cart_sub_tb import cart_pkg::*; ();

   localparam int NUM_TESTS = 6;
   localparam int MAX_OPS   = 8;
   localparam int IMG_WORDS = 260 * 8 + 2;   // rom and ram banks followed by two header words
   localparam logic [1:0] K_DL = 2'd0;
   localparam logic [1:0] K_RD = 2'd1;
   localparam logic [1:0] K_WR = 2'd2;

   typedef struct packed {
      logic [1:0] kind;
      cart_addr_t addr;
      cart_byte_t data;
      bank_t      bank;      // 8k bank a read must land in
   } op_t;

   logic       clk4 = 1'b0;
   logic       reset;
   logic       dl_active;
   logic       dl_wr;
   waddr_t     dl_addr;
   word_t      dl_data;
   cart_addr_t cart_addr;
   logic       cart_rd;
   logic       cart_wr;
   cart_byte_t cart_di;
   cart_byte_t cart_do;
   logic       busy;
   logic       done;
   bank_t      exp_bank;
   int         test_num;
   logic       test_end;
   int         checks;
   int         chk_errors;
   op_t        ops [NUM_TESTS][MAX_OPS];
   int         n_ops [NUM_TESTS];
   cart_byte_t hdr_type [NUM_TESTS];
   cart_byte_t hdr_rom [NUM_TESTS];
   cart_byte_t hdr_ram [NUM_TESTS];
   int         bench_errors = 0;
   int         cycles = 0;
   int         limit = 0;
   int         total_errors;

   always #50 clk4 = ~clk4;

   cart_sub dut0 (
      .clk4 (clk4), .reset (reset),
      .dl_active (dl_active), .dl_wr (dl_wr), .dl_addr (dl_addr), .dl_data (dl_data),
      .cart_addr (cart_addr), .cart_rd (cart_rd), .cart_wr (cart_wr), .cart_di (cart_di),
      .cart_do (cart_do), .busy (busy), .done (done)
   );

   cart_sub_check chk0 (
      .clk4 (clk4), .reset (reset),
      .dl_active (dl_active), .dl_wr (dl_wr), .dl_addr (dl_addr), .dl_data (dl_data),
      .cart_addr (cart_addr), .cart_rd (cart_rd), .cart_wr (cart_wr), .cart_di (cart_di),
      .cart_do (cart_do), .done (done), .exp_bank (exp_bank),
      .test_num (test_num), .test_end (test_end), .checks (checks), .errors (chk_errors)
   );

   bind cart_sub cart_sub_assert asrt0 (
      .clk4 (clk4), .reset (reset), .dl_wr (dl_wr), .cart_rd (cart_rd), .cart_wr (cart_wr),
      .busy (busy), .done (done), .req (mem0.req), .ack (mem0.ack)
   );

   // --------------------
   // run limit
   always @(posedge clk4) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("** FAIL **");
         $finish;
      end
   end

   task automatic set_hdr(input int r, input cart_byte_t t, input cart_byte_t rc,
                          input cart_byte_t ac);
      hdr_type[r] = t;
      hdr_rom[r] = rc;
      hdr_ram[r] = ac;
      n_ops[r] = 0;
   endtask

   task automatic add_op(input int r, input logic [1:0] kind, input cart_addr_t a,
                         input cart_byte_t d, input bank_t b);
      ops[r][n_ops[r]] = '{kind, a, d, b};
      n_ops[r]++;
   endtask

   // one strobe followed by a wait for done when an access starts
   task automatic pulse_and_wait(input logic [1:0] kind);
      @(posedge clk4);
      #1;
      dl_wr = (kind == K_DL);
      cart_rd = (kind == K_RD);
      cart_wr = (kind == K_WR);
      @(posedge clk4);
      #1;
      dl_wr = 1'b0;
      cart_rd = 1'b0;
      cart_wr = 1'b0;
      if (busy) begin
         while (!done) begin
            @(posedge clk4);
            #1;
         end
      end else if (kind != K_WR) begin
         $display("error: a download write or read at %0t did not start an access", $time);
         bench_errors++;
      end
   endtask

   task automatic download(input int r);
      int b;
      int w;
      dl_active = 1'b1;
      for (b = 0; b < 260; b++) begin          // 256 rom banks followed by ram banks 0..3
         for (w = 0; w < 8; w++) begin
            dl_addr = waddr_t'(b * 4096 + w);
            dl_data = word_t'(32'(dl_addr) * 32'h9E37 + 32'(dl_addr));
            pulse_and_wait(K_DL);
         end
      end
      dl_addr = `HDR_TYPE_WADDR;
      dl_data = {8'h00, hdr_type[r]};
      pulse_and_wait(K_DL);
      dl_addr = `HDR_SIZE_WADDR;
      dl_data = {hdr_rom[r], hdr_ram[r]};
      pulse_and_wait(K_DL);
      dl_active = 1'b0;
   endtask

   task automatic run_test(input int r);
      int         i;
      logic [3:0] ofs;
      op_t        op;
      download(r);
      ofs = 4'(($urandom % 8) * 2);              // even offset keeps the byte parity
      for (i = 0; i < n_ops[r]; i++) begin
         op = ops[r][i];
         cart_addr = (op.kind == K_RD || op.addr[15]) ? op.addr + 16'(ofs) : op.addr;
         cart_di = op.data;
         exp_bank = op.bank;
         pulse_and_wait(op.kind);
      end
      test_num = r;
      test_end = 1'b1;
      @(posedge clk4);
      #1;
      test_end = 1'b0;
   endtask

   initial begin
      int r;
      void'($urandom(32'had2a_c2d4));
      reset = 1'b1;
      dl_active = 1'b0;
      dl_wr = 1'b0;
      dl_addr = '0;
      dl_data = '0;
      cart_addr = '0;
      cart_rd = 1'b0;
      cart_wr = 1'b0;
      cart_di = '0;
      exp_bank = '0;
      test_num = 0;
      test_end = 1'b0;
      // --------------------
      // stimulus table with banks worked out by hand
      set_hdr(0, 8'h01, 8'h06, 8'h03);         // reset defaults
      add_op(0, K_RD, 16'h4000, 8'h00, 9'h002);
      add_op(0, K_RD, 16'h4001, 8'h00, 9'h002);
      set_hdr(1, 8'h00, 8'h00, 8'h00);         // linear map without a mapper
      add_op(1, K_WR, 16'h2000, 8'h07, 9'h000);   // ignored by the linear map
      add_op(1, K_RD, 16'h0000, 8'h00, 9'h000);
      add_op(1, K_RD, 16'h2001, 8'h00, 9'h001);
      add_op(1, K_RD, 16'h4000, 8'h00, 9'h002);
      add_op(1, K_RD, 16'h6001, 8'h00, 9'h003);
      set_hdr(2, 8'h01, 8'h05, 8'h00);         // bank switching
      add_op(2, K_WR, 16'h2000, 8'h05, 9'h000);
      add_op(2, K_RD, 16'h4000, 8'h00, 9'h00A);
      add_op(2, K_RD, 16'h6001, 8'h00, 9'h00B);
      add_op(2, K_WR, 16'h2000, 8'h00, 9'h000);   // 0 acts as 1
      add_op(2, K_RD, 16'h4001, 8'h00, 9'h002);
      set_hdr(3, 8'h02, 8'h01, 8'h02);         // 64k rom mirrors bank 6 onto 2
      add_op(3, K_WR, 16'h2000, 8'h06, 9'h000);
      add_op(3, K_RD, 16'h4000, 8'h00, 9'h004);
      add_op(3, K_RD, 16'h6001, 8'h00, 9'h005);
      set_hdr(4, 8'h03, 8'h05, 8'h03);         // upper rom bits from the ram register
      add_op(4, K_WR, 16'h4000, 8'h01, 9'h000);
      add_op(4, K_WR, 16'h2000, 8'h03, 9'h000);
      add_op(4, K_RD, 16'h4000, 8'h00, 9'h046);   // rom bank 35
      add_op(4, K_WR, 16'h4000, 8'h02, 9'h000);
      add_op(4, K_RD, 16'h4001, 8'h00, 9'h006);   // 67 masked to 3
      add_op(4, K_WR, 16'h4000, 8'h01, 9'h000);   // bank 35 again in mode 0
      add_op(4, K_WR, 16'h6000, 8'h01, 9'h000);
      add_op(4, K_RD, 16'h6000, 8'h00, 9'h007);   // mode 1 clears upper bits
      set_hdr(5, 8'h03, 8'h00, 8'h03);         // ram gating in mode 1 with 4 ram banks
      add_op(5, K_WR, 16'h4000, 8'h02, 9'h000);   // ram bank 2
      add_op(5, K_WR, 16'hA000, 8'h5A, 9'h000);   // ram locked so the write is dropped
      add_op(5, K_RD, 16'hA000, 8'h00, 9'h102);
      add_op(5, K_WR, 16'h0000, 8'h0A, 9'h000);
      add_op(5, K_WR, 16'hA000, 8'h3C, 9'h000);
      add_op(5, K_RD, 16'hA000, 8'h00, 9'h102);
      add_op(5, K_WR, 16'h4000, 8'h00, 9'h000);
      add_op(5, K_RD, 16'hA000, 8'h00, 9'h100);
      for (r = 0; r < NUM_TESTS; r++)
         limit += IMG_WORDS + n_ops[r];
      limit = limit * 10 * 8 + 8;
      repeat (8) begin
         @(posedge clk4);
         #1;
         if (busy !== 1'b0 || done !== 1'b0) begin
            $display("error: busy or done not low during reset at %0t", $time);
            bench_errors++;
         end
      end
      reset = 1'b0;
      for (r = 0; r < NUM_TESTS; r++)
         run_test(r);
      @(posedge clk4);
      #1;
      total_errors = chk_errors + bench_errors + dut0.asrt0.fail_count;
      $display("summary: %0d tests, %0d reads checked, %0d errors", NUM_TESTS, checks,
               total_errors);
      if (total_errors == 0 && checks > 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== cart_mapper/bank_map.sv ====
// MBC1 address translation from the cpu bus to a store word address
// purely combinational, reads outside 0000-7FFF and A000-BFFF land in bank 0
`include "cart_defines.svh"

module bank_map import cart_pkg::*; (
   input  cart_addr_t            cart_addr,
   input  logic                  cart_wr,
   input  logic [`ROM_REG_W-1:0] rom_bank_reg,
   input  ram_bank_t             ram_bank_reg,
   input  logic                  bank_mode,
   input  logic                  ram_enable,
   input  logic                  is_mbc1,
   input  rom_bank_t             rom_mask,
   input  ram_bank_t             ram_mask,
   output waddr_t                word_addr,      // {bank, offset}
   output logic                  ram_write_ok    // write may reach the store
);

   logic [2:0] win;         // 8k window
   rom_bank_t  rom_sel;     // rom bank before mirroring
   rom_bank_t  rom_bank;
   ram_bank_t  ram_bank;
   bank_t      mbc1_bank;
   bank_t      bank;

   assign win = cart_addr[15:13];

   // --------------------
   // rom banking
   // mode 0 puts the ram bank register on the upper rom lines
   assign rom_sel  = {bank_mode ? ram_bank_t'(0) : ram_bank_reg, rom_bank_reg};
   assign rom_bank = rom_sel & rom_mask;          // mirror small roms

   // ram bank register only counts in mode 1
   assign ram_bank = (bank_mode ? ram_bank_reg : ram_bank_t'(0)) & ram_mask;

   // --------------------
   // bank by region
   always_comb begin
      mbc1_bank = '0;
      case (cart_addr[15:14])
         2'b00: mbc1_bank = {8'd0, cart_addr[13]};             // fixed bank 0
         2'b01: mbc1_bank = {1'b0, rom_bank, cart_addr[13]};   // switched 16k
         default: begin
            if (win == `WIN_CART_RAM)
               mbc1_bank = {1'b1, 6'd0, ram_bank};             // ram region
         end
      endcase
   end

   // without a mapper the 32k image is mapped linearly
   assign bank = is_mbc1 ? mbc1_bank : {7'd0, cart_addr[14:13]};

   assign word_addr = {bank, cart_addr[`CART_OFS_W:1]};   // bit 0 picks the byte

   // ram writes only through the A000 window and only when enabled
   assign ram_write_ok = cart_wr && ram_enable && (win == `WIN_CART_RAM);

endmodule

// ==== cart_mapper/header_capture.sv ====
// picks the mapper type and size codes out of the download stream
// fields stay as captured until reset, a new download overwrites them
`include "cart_defines.svh"

module header_capture import cart_pkg::*; (
   input  logic       clk4,
   input  logic       reset,
   input  logic       dl_active,   // host download in progress
   input  logic       dl_wr,
   input  waddr_t     dl_addr,
   input  word_t      dl_data,
   output logic       is_mbc1,
   output rom_bank_t  rom_mask,    // mirrors banks beyond the rom size
   output ram_bank_t  ram_mask
);

   cart_byte_t type_code;   // byte 147h
   cart_byte_t rom_code;    // byte 148h
   cart_byte_t ram_code;    // byte 149h
   logic       hdr_wr;

   assign hdr_wr = dl_active && dl_wr;

   // --------------------
   // snoop the two header words
   always_ff @(posedge clk4) begin
      if (reset) begin
         type_code <= '0;
         rom_code  <= '0;
         ram_code  <= '0;
      end else if (hdr_wr) begin
         if (dl_addr == `HDR_TYPE_WADDR)
            type_code <= dl_data[7:0];             // odd byte sits low
         if (dl_addr == `HDR_SIZE_WADDR)
            {rom_code, ram_code} <= dl_data;
      end
   end

   // types 1..3 are mbc1, mbc1+ram, mbc1+ram+battery
   assign is_mbc1 = (type_code >= 8'd1) && (type_code <= 8'd3);

   // code n gives n+1 low ones, capped at 7
   assign rom_mask = (rom_code >= 8'd6) ? '1 : rom_bank_t'((8'd2 << rom_code) - 8'd1);

   // 2k and 8k parts have a single bank
   assign ram_mask = ((ram_code == 8'd1) || (ram_code == 8'd2)) ? '0 : '1;

endmodule

// ==== cart_mapper/mbc1_regs.sv ====
// MBC1 control registers, written through the four 8k windows below 8000h
// writes to the ram window and above are not decoded here
`include "cart_defines.svh"

module mbc1_regs import cart_pkg::*; (
   input  logic                  clk4,
   input  logic                  reset,
   input  logic                  cart_wr,        // one cycle strobe
   input  cart_addr_t            cart_addr,
   input  cart_byte_t            cart_di,
   output logic [`ROM_REG_W-1:0] rom_bank_reg,   // lower rom bank bits
   output ram_bank_t             ram_bank_reg,   // ram bank or upper rom bits
   output logic                  bank_mode,      // 0 rom banking, 1 ram banking
   output logic                  ram_enable
);

   logic [2:0] win;          // which 8k window
   logic       rom_area_wr;  // write below 8000h

   assign win         = cart_addr[15:13];
   assign rom_area_wr = cart_wr && !cart_addr[15];

   // --------------------
   // register writes
   always_ff @(posedge clk4) begin
      if (reset) begin
         rom_bank_reg <= `ROM_REG_W'(1);   // bank 1 at 4000h out of reset
         ram_bank_reg <= '0;
         bank_mode    <= 1'b0;
         ram_enable   <= 1'b0;             // ram locked until the key
      end else if (rom_area_wr) begin
         case (win)
            `WIN_RAM_EN: begin
               // any other value locks ram again
               ram_enable <= (cart_di[3:0] == `RAM_EN_KEY);
            end
            `WIN_ROM_BANK: begin
               if (cart_di[`ROM_REG_W-1:0] == '0) begin
                  rom_bank_reg <= `ROM_REG_W'(1);   // 0 would alias bank 0
               end else begin
                  rom_bank_reg <= cart_di[`ROM_REG_W-1:0];
               end
            end
            `WIN_RAM_BANK: begin
               ram_bank_reg <= cart_di[`RAM_BANK_W-1:0];   // upper bits ignored
            end
            `WIN_MODE: begin
               bank_mode <= cart_di[0];
            end
            default: begin
               // no other window below 8000h
            end
         endcase
      end
   end

endmodule

// ==== cart_sub.f ====
+incdir+common
common/cart_pkg.sv
common/mem_if.sv
cart_mapper/mbc1_regs.sv
cart_mapper/header_capture.sv
cart_mapper/bank_map.sv
design/mem_arbiter.sv
design/word_store.sv
design/cart_sub.sv
bench/cart_sub_assert.sv
bench/cart_sub_check.sv
bench/cart_sub_tb.sv

// ==== common/cart_defines.svh ====
// cartridge format widths, MBC1 window codes and header locations
// header addresses are word addresses into the 16-bit store
`ifndef CART_DEFINES_SVH
`define CART_DEFINES_SVH

// --------------------
// widths
`define CART_ADDR_W     16          // cpu side cartridge bus
`define CART_BYTE_W     8
`define CART_WORD_W     16          // backing store word
`define CART_BE_W       2           // one enable per byte of a word
`define CART_WADDR_W    21          // 9 bank bits + 12 offset bits
`define CART_BANK_W     9           // bit 8 picks the ram region
`define CART_OFS_W      12          // word offset inside an 8k window
`define ROM_BANK_W      7           // up to 128 x 16k rom banks
`define ROM_REG_W       5           // lower rom bank register
`define RAM_BANK_W      2           // up to 4 x 8k ram banks

// --------------------
// 8k windows, cart_addr[15:13]
`define WIN_RAM_EN      3'b000      // 0000-1FFF ram enable
`define WIN_ROM_BANK    3'b001      // 2000-3FFF rom bank low bits
`define WIN_RAM_BANK    3'b010      // 4000-5FFF ram bank / rom high bits
`define WIN_MODE        3'b011      // 6000-7FFF banking mode
`define WIN_CART_RAM    3'b101      // A000-BFFF external ram

`define HDR_TYPE_WADDR  21'h0000A3  // low byte is image byte 147h
`define HDR_SIZE_WADDR  21'h0000A4  // rom size code high, ram size code low
`define RAM_EN_KEY      4'hA        // only this nibble enables ram

`endif

// ==== common/cart_pkg.sv ====
// shared types of the cartridge subsystem
// widths come from the defines header, nothing here is configurable
`include "cart_defines.svh"

package cart_pkg;

   // --------------------
   // bus side
   typedef logic [`CART_ADDR_W-1:0]  cart_addr_t;   // cpu byte address
   typedef logic [`CART_BYTE_W-1:0]  cart_byte_t;   // cpu data byte

   // store side
   typedef logic [`CART_WORD_W-1:0]  word_t;        // even byte in the high half
   typedef logic [`CART_WADDR_W-1:0] waddr_t;       // {bank, offset}

   // --------------------
   // banking
   typedef logic [`CART_BANK_W-1:0]  bank_t;        // translated 8k bank
   typedef logic [`ROM_BANK_W-1:0]   rom_bank_t;
   typedef logic [`RAM_BANK_W-1:0]   ram_bank_t;

   // requester side of the four-phase handshake
   typedef enum logic [1:0] {
      ARB_IDLE,       // waiting for a strobe
      ARB_REQ,        // req high, waiting for ack
      ARB_WAIT_REL,   // req dropped, waiting for ack low
      ARB_FINISH      // one cycle done pulse
   } arb_state_t;

endpackage

// ==== common/mem_if.sv ====
// four-phase req/ack link between the arbiter and the word store
// fields must stay stable while req is high
`include "cart_defines.svh"

interface mem_if import cart_pkg::*; ();

   logic                  req;     // held until ack seen
   logic                  we;      // 1 write, 0 read
   waddr_t                addr;
   logic [`CART_BE_W-1:0] be;      // [1] high byte, [0] low byte
   word_t                 wdata;
   logic                  ack;     // dropped once req is low
   word_t                 rdata;   // registered together with ack

   // arbiter side
   modport requester (
      output req, we, addr, be, wdata,
      input  ack, rdata
   );

   // memory side
   modport store (
      input  req, we, addr, be, wdata,
      output ack, rdata
   );

endinterface

// ==== design/cart_sub.sv ====
// cartridge side top: download port in, byte-wide cart bus out
// one access in flight, callers wait for done before the next strobe
`include "cart_defines.svh"

module cart_sub import cart_pkg::*; (
   input  logic       clk4,
   input  logic       reset,
   input  logic       dl_active,    // host image download
   input  logic       dl_wr,
   input  waddr_t     dl_addr,
   input  word_t      dl_data,
   input  cart_addr_t cart_addr,    // console cartridge bus
   input  logic       cart_rd,
   input  logic       cart_wr,
   input  cart_byte_t cart_di,
   output cart_byte_t cart_do,
   output logic       busy,
   output logic       done
);

   // --------------------
   // mapper state
   logic [`ROM_REG_W-1:0] rom_bank_reg;
   ram_bank_t             ram_bank_reg;
   logic                  bank_mode;
   logic                  ram_enable;
   logic                  is_mbc1;
   rom_bank_t             rom_mask;
   ram_bank_t             ram_mask;
   waddr_t                word_addr;
   logic                  ram_write_ok;

   mem_if mem0 ();   // arbiter to store

   mbc1_regs regs0 (
      .clk4 (clk4), .reset (reset),
      .cart_wr (cart_wr), .cart_addr (cart_addr), .cart_di (cart_di),
      .rom_bank_reg (rom_bank_reg), .ram_bank_reg (ram_bank_reg),
      .bank_mode (bank_mode), .ram_enable (ram_enable)
   );

   header_capture hdr0 (
      .clk4 (clk4), .reset (reset),
      .dl_active (dl_active), .dl_wr (dl_wr), .dl_addr (dl_addr), .dl_data (dl_data),
      .is_mbc1 (is_mbc1), .rom_mask (rom_mask), .ram_mask (ram_mask)
   );

   bank_map map0 (
      .cart_addr (cart_addr), .cart_wr (cart_wr),
      .rom_bank_reg (rom_bank_reg), .ram_bank_reg (ram_bank_reg),
      .bank_mode (bank_mode), .ram_enable (ram_enable),
      .is_mbc1 (is_mbc1), .rom_mask (rom_mask), .ram_mask (ram_mask),
      .word_addr (word_addr), .ram_write_ok (ram_write_ok)
   );

   // --------------------
   // memory path
   mem_arbiter arb0 (
      .clk4 (clk4), .reset (reset),
      .dl_active (dl_active), .dl_wr (dl_wr), .dl_addr (dl_addr), .dl_data (dl_data),
      .cart_rd (cart_rd), .cart_wr (cart_wr), .ram_write_ok (ram_write_ok),
      .word_addr (word_addr), .cart_a0 (cart_addr[0]), .cart_di (cart_di),
      .cart_do (cart_do), .busy (busy), .done (done),
      .mem (mem0)
   );

   word_store store0 (
      .clk4 (clk4), .reset (reset),
      .mem (mem0)
   );

endmodule

// ==== design/mem_arbiter.sv ====
// one access at a time, download traffic wins while dl_active is high
// strobes arriving while busy are dropped
`include "cart_defines.svh"

module mem_arbiter import cart_pkg::*; (
   input  logic       clk4,
   input  logic       reset,
   input  logic       dl_active,
   input  logic       dl_wr,        // one cycle word write
   input  waddr_t     dl_addr,
   input  word_t      dl_data,
   input  logic       cart_rd,      // one cycle strobes
   input  logic       cart_wr,
   input  logic       ram_write_ok,
   input  waddr_t     word_addr,    // translated by bank_map
   input  logic       cart_a0,      // byte select
   input  cart_byte_t cart_di,
   output cart_byte_t cart_do,
   output logic       busy,
   output logic       done,
   mem_if.requester   mem
);

   arb_state_t            state;
   logic                  req_q;
   logic                  we_q;
   logic                  lo_q;       // odd address, low half of the word
   waddr_t                addr_q;
   logic [`CART_BE_W-1:0] be_q;
   word_t                 wdata_q;
   logic                  dl_start;
   logic                  rd_start;
   logic                  wr_start;
   logic                  start;

   // --------------------
   // request sources
   assign dl_start = dl_active && dl_wr;
   assign rd_start = !dl_active && cart_rd;
   assign wr_start = !dl_active && !cart_rd && cart_wr && ram_write_ok;  // gated by mapper
   assign start    = dl_start || rd_start || wr_start;

   // handshake control
   always_ff @(posedge clk4) begin
      if (reset) begin
         state <= ARB_IDLE;
         req_q <= 1'b0;
      end else begin
         case (state)
            ARB_IDLE: begin
               if (start) begin
                  req_q <= 1'b1;
                  state <= ARB_REQ;
               end
            end
            ARB_REQ: begin
               if (mem.ack) begin
                  req_q <= 1'b0;                   // release on ack
                  state <= ARB_WAIT_REL;
               end
            end
            ARB_WAIT_REL: begin
               if (!mem.ack)
                  state <= ARB_FINISH;             // store released, next req allowed
            end
            default: state <= ARB_IDLE;            // finish lasts one cycle
         endcase
      end
   end

   // --------------------
   // payload latched at the strobe, held while req is up
   always_ff @(posedge clk4) begin
      if (state == ARB_IDLE && start) begin
         if (dl_start) begin
            we_q    <= 1'b1;
            addr_q  <= dl_addr;
            be_q    <= '1;                         // whole word
            wdata_q <= dl_data;
            lo_q    <= 1'b0;
         end else begin
            we_q    <= wr_start;
            addr_q  <= word_addr;
            be_q    <= cart_a0 ? 2'b01 : 2'b10;    // even byte is the high half
            wdata_q <= {cart_di, cart_di};         // same byte on both lanes
            lo_q    <= cart_a0;
         end
      end
      if (state == ARB_REQ && mem.ack && !we_q)
         cart_do <= lo_q ? mem.rdata[7:0] : mem.rdata[15:8];   // held until next read
   end

   assign mem.req   = req_q;
   assign mem.we    = we_q;
   assign mem.addr  = addr_q;
   assign mem.be    = be_q;
   assign mem.wdata = wdata_q;

   assign busy = (state != ARB_IDLE);
   assign done = (state == ARB_FINISH);

endmodule

// ==== design/word_store.sv ====
// synchronous 2M x 16 word memory standing in for the SDRAM
// contents are undefined until written, reset only clears the handshake
`include "cart_defines.svh"

module word_store import cart_pkg::*; (
   input  logic  clk4,
   input  logic  reset,
   mem_if.store  mem
);

   // --------------------
   // storage
   word_t store_mem [0:(1 << `CART_WADDR_W) - 1];   // rom below 100000h, ram above

   logic take;   // new request not yet answered

   assign take = mem.req && !mem.ack;

   // --------------------
   // ack side of the four-phase handshake
   always_ff @(posedge clk4) begin
      if (reset) begin
         mem.ack <= 1'b0;
      end else if (take) begin
         mem.ack <= 1'b1;                 // one cycle after req is seen
      end else if (!mem.req) begin
         mem.ack <= 1'b0;                 // release once req is gone
      end
   end

   // array access happens once per request
   always_ff @(posedge clk4) begin
      if (take) begin
         if (mem.we && mem.be[1])
            store_mem[mem.addr][15:8] <= mem.wdata[15:8];
         if (mem.we && mem.be[0])
            store_mem[mem.addr][7:0] <= mem.wdata[7:0];
         mem.rdata <= store_mem[mem.addr];   // old data on a write
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass message in sim.log
rm -rf obj_dir sim.log &&
verilator --binary --assert -Wno-fatal --top-module cart_sub_tb -f cart_sub.f \
   -Mdir obj_dir > sim.log 2>&1 &&
./obj_dir/Vcart_sub_tb +verilator+error+limit+100 >> sim.log 2>&1
grep -qF '** PASS **' sim.log && echo "simulation passed" ||
   { echo "simulation failed, see sim.log"; exit 1; }
